// ==== logic/mul_pkg.sv ====
////////////////////////////////////////////////////////////
// multiplier types shared by the station and the pipeline
// func follows the RV32M multiply group, only four ops
// tag and rob widths live here so rs_pkg can build on them
// the issue packet carries resolved values only, never tags
////////////////////////////////////////////////////////////

package mul_pkg;

    localparam int xlen        = 32; // data width
    localparam int mul_latency = 3;  // issue_valid to result_valid
    localparam int tag_w       = 6;  // physical register tag
    localparam int rob_idx_w   = 5;  // reorder buffer index

    // multiply opcodes
    // mul keeps the low word, the rest keep the high word
    typedef enum logic [1:0] {
        mul    = 2'b00, // low 32, sign does not matter
        mulh   = 2'b01, // high 32, signed x signed
        mulhsu = 2'b10, // high 32, signed x unsigned
        mulhu  = 2'b11  // high 32, unsigned x unsigned
    } mul_func_e;

    // packet from the selector into the multiplier
    typedef struct packed {
        logic [xlen-1:0]      opa;
        logic [xlen-1:0]      opb;
        mul_func_e            func;
        logic [tag_w-1:0]     dest;
        logic [rob_idx_w-1:0] rob;
    } mul_issue_t;

    // result leaving the subsystem, 43 bits
    typedef struct packed {
        logic [xlen-1:0]      value;
        logic [tag_w-1:0]     dest;
        logic [rob_idx_w-1:0] rob;
    } mul_result_t;

endpackage

// ==== logic/rs_pkg.sv ====
////////////////////////////////////////////////////////////
// reservation station sizes and the structs at its edges
// an operand is either a value (ready) or a pending tag
// the cdb is a plain valid strobe with no handshake
// compile after mul_pkg, widths are taken from it
////////////////////////////////////////////////////////////

package rs_pkg;

    localparam int rs_size  = 4;                  // entries
    localparam int rs_idx_w = 2;                  // entry index width
    localparam int preg_w   = mul_pkg::tag_w;     // physical register tag
    localparam int rob_w    = mul_pkg::rob_idx_w; // rob index

    // source operand as it arrives from rename, 39 bits
    typedef struct packed {
        logic                     ready; // value valid, tag ignored
        logic [mul_pkg::xlen-1:0] value;
        logic [preg_w-1:0]        tag;   // producer, used while not ready
    } operand_t;

    // one instruction at dispatch
    typedef struct packed {
        operand_t               opa;
        operand_t               opb;
        mul_pkg::mul_func_e     func;
        logic [preg_w-1:0]      dest;
        logic [rob_w-1:0]       rob;
    } rs_dispatch_t;

    // common data bus, seen by every entry
    typedef struct packed {
        logic                     valid;
        logic [preg_w-1:0]        tag;
        logic [mul_pkg::xlen-1:0] value;
    } cdb_t;

    // what a slot keeps
    // data holds the value when ready, else the tag in its low bits
    typedef struct packed {
        logic                     opa_ready;
        logic [mul_pkg::xlen-1:0] opa_data;
        logic                     opb_ready;
        logic [mul_pkg::xlen-1:0] opb_data;
        mul_pkg::mul_func_e       func;
        logic [preg_w-1:0]        dest;
        logic [rob_w-1:0]         rob;
    } rs_entry_t;

endpackage

// ==== logic/rs_dispatch.sv ====
////////////////////////////////////////////////////////////
// free slot pick and occupancy count for the station
// dispatch while full is illegal and gets no slot
// count moves by +1 per dispatch and -1 per issue
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_dispatch (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       dispatch_valid,
    input  logic [rs_pkg::rs_size-1:0] busy,
    input  logic                       issue_grant_any,
    output logic [rs_pkg::rs_size-1:0] alloc,
    output logic                       full
);

    logic [rs_pkg::rs_idx_w:0]   count;     // 0 .. rs_size
    logic [rs_pkg::rs_idx_w-1:0] free_idx;  // lowest free slot
    logic                        any_free;

    ////////////////////////////////////////////////////////////
    // free slot search
    ////////////////////////////////////////////////////////////

    // walk down so the lowest free index wins
    always_comb begin
        free_idx = '0;
        any_free = 1'b0;
        for (int i = rs_pkg::rs_size - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = rs_pkg::rs_idx_w'(i);
                any_free = 1'b1;
            end
        end
    end

    // one-hot, only on a real dispatch
    always_comb begin
        alloc = '0;
        if (dispatch_valid && any_free)
            alloc[free_idx] = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            count <= '0;                   // flush empties every slot
        end else begin
            case ({dispatch_valid, issue_grant_any})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither, no change
            endcase
        end
    end

    assign full = (count == (rs_pkg::rs_idx_w + 1)'(rs_pkg::rs_size));

endmodule

// ==== logic/rs_entry.sv ====
////////////////////////////////////////////////////////////
// one station slot
// snoops the cdb while busy and also in the dispatch cycle
// requests issue once both operands hold values
// alloc and grant never hit the same slot in one cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_entry (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 alloc,
    input  rs_pkg::rs_dispatch_t dispatch,
    input  rs_pkg::cdb_t         cdb,
    input  logic                 grant,
    output logic                 busy,
    output logic                 request,
    output mul_pkg::mul_issue_t  entry_issue
);

    rs_pkg::rs_entry_t        slot;
    logic [mul_pkg::xlen:0]   opa_in;   // {ready, data} at write time
    logic [mul_pkg::xlen:0]   opb_in;
    logic                     opa_hit;  // wakeup of a stored operand
    logic                     opb_hit;

    // resolve an incoming operand against the bus in the same cycle
    function automatic logic [mul_pkg::xlen:0] resolve(
        input rs_pkg::operand_t op,
        input rs_pkg::cdb_t     bus
    );
        logic hit;
        hit = bus.valid && !op.ready && (bus.tag == op.tag);
        if (op.ready)
            resolve = {1'b1, op.value};
        else if (hit)
            resolve = {1'b1, bus.value};   // broadcast in dispatch cycle
        else
            resolve = {1'b0, {(mul_pkg::xlen - rs_pkg::preg_w){1'b0}}, op.tag};
    endfunction

    assign opa_in = resolve(dispatch.opa, cdb);
    assign opb_in = resolve(dispatch.opb, cdb);

    // tag sits in the low bits of data while not ready
    assign opa_hit = cdb.valid && !slot.opa_ready
                     && (slot.opa_data[rs_pkg::preg_w-1:0] == cdb.tag);
    assign opb_hit = cdb.valid && !slot.opb_ready
                     && (slot.opb_data[rs_pkg::preg_w-1:0] == cdb.tag);

    ////////////////////////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush)
            busy <= 1'b0;
        else if (alloc)
            busy <= 1'b1;
        else if (grant)
            busy <= 1'b0;   // leaves for the multiplier this edge
    end

    ////////////////////////////////////////////////////////////
    // payload, write or wakeup
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc) begin
            {slot.opa_ready, slot.opa_data} <= opa_in;
            {slot.opb_ready, slot.opb_data} <= opb_in;
            slot.func <= dispatch.func;
            slot.dest <= dispatch.dest;
            slot.rob  <= dispatch.rob;
        end else if (busy) begin
            if (opa_hit) begin
                slot.opa_ready <= 1'b1;
                slot.opa_data  <= cdb.value;
            end
            if (opb_hit) begin
                slot.opb_ready <= 1'b1;
                slot.opb_data  <= cdb.value;
            end
        end
    end

    assign request = busy && slot.opa_ready && slot.opb_ready;

    // both data fields are values whenever request is high
    assign entry_issue = '{opa:  slot.opa_data,
                           opb:  slot.opb_data,
                           func: slot.func,
                           dest: slot.dest,
                           rob:  slot.rob};

endmodule

// ==== logic/rs_issue_select.sv ====
////////////////////////////////////////////////////////////
// fixed priority issue, lowest entry index first
// grant is combinational, the packet is registered
// no fairness, a low slot that keeps requesting wins
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_issue_select (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       flush,
    input  logic [rs_pkg::rs_size-1:0] request,
    input  mul_pkg::mul_issue_t        entry_issue [rs_pkg::rs_size],
    output logic [rs_pkg::rs_size-1:0] grant,
    output logic                       issue_grant_any,
    output logic                       issue_valid,
    output mul_pkg::mul_issue_t        issue
);

    logic [rs_pkg::rs_idx_w-1:0] sel_idx;   // index of the granted slot

    ////////////////////////////////////////////////////////////
    // priority pick
    ////////////////////////////////////////////////////////////

    always_comb begin
        sel_idx = '0;
        for (int i = rs_pkg::rs_size - 1; i >= 0; i--) begin
            if (request[i])
                sel_idx = rs_pkg::rs_idx_w'(i);   // last hit is the lowest
        end
    end

    always_comb begin
        grant = '0;
        if (|request)
            grant[sel_idx] = 1'b1;
    end

    assign issue_grant_any = |request;

    ////////////////////////////////////////////////////////////
    // issue register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush)
            issue_valid <= 1'b0;
        else
            issue_valid <= issue_grant_any;   // drops in idle cycles
    end

    // payload only, qualified by issue_valid
    always_ff @(posedge clock) begin
        if (issue_grant_any)
            issue <= entry_issue[sel_idx];
    end

endmodule

// ==== logic/mul_pipe.sv ====
////////////////////////////////////////////////////////////
// three stage 33x33 signed multiplier
// takes one op per cycle, no stall input
// stage 1 extends, stage 2 multiplies, stage 3 picks a half
// flush kills every op in flight
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mul_pipe (
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    input  logic                issue_valid,
    input  mul_pkg::mul_issue_t issue,
    output logic                result_valid,
    output mul_pkg::mul_result_t result
);

    // side band that follows each op down the pipe
    typedef struct packed {
        mul_pkg::mul_func_e              func;
        logic [mul_pkg::tag_w-1:0]       dest;
        logic [mul_pkg::rob_idx_w-1:0]   rob;
    } side_t;

    logic [mul_pkg::mul_latency-1:0] valid_sr;   // bit k = stage k+1
    side_t                           s1_side;
    side_t                           s2_side;
    logic signed [mul_pkg::xlen:0]   s1_a;       // 33 bit extended
    logic signed [mul_pkg::xlen:0]   s1_b;
    logic signed [2*mul_pkg::xlen+1:0] s2_prod;  // 66 bit product
    logic                            a_signed;
    logic                            b_signed;

    // opa is unsigned only for mulhu, opb is signed only for mulh
    // mul takes the low half so its extension is irrelevant
    assign a_signed = (issue.func != mul_pkg::mulhu);
    assign b_signed = (issue.func == mul_pkg::mulh) || (issue.func == mul_pkg::mul);

    ////////////////////////////////////////////////////////////
    // valids
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush)
            valid_sr <= '0;
        else
            valid_sr <= {valid_sr[mul_pkg::mul_latency-2:0], issue_valid};
    end

    assign result_valid = valid_sr[mul_pkg::mul_latency-1];

    ////////////////////////////////////////////////////////////
    // datapath, no reset
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        // stage 1, extend
        s1_a    <= {a_signed & issue.opa[mul_pkg::xlen-1], issue.opa};
        s1_b    <= {b_signed & issue.opb[mul_pkg::xlen-1], issue.opb};
        s1_side <= '{func: issue.func, dest: issue.dest, rob: issue.rob};

        // stage 2, multiply
        s2_prod <= s1_a * s1_b;
        s2_side <= s1_side;

        // stage 3, low or high word
        if (s2_side.func == mul_pkg::mul)
            result.value <= s2_prod[mul_pkg::xlen-1:0];
        else
            result.value <= s2_prod[2*mul_pkg::xlen-1:mul_pkg::xlen];
        result.dest <= s2_side.dest;
        result.rob  <= s2_side.rob;
    end

endmodule

// ==== logic/rs_mul_top.sv ====
////////////////////////////////////////////////////////////
// multiply reservation station with its own multiplier
// the caller must not dispatch while full is high
// results leave here, the core drives the cdb back in
// flush drops all waiting and in flight ops
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_mul_top (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  rs_pkg::rs_dispatch_t dispatch,
    input  rs_pkg::cdb_t         cdb,
    input  logic                 flush,
    output logic                 full,
    output logic                 result_valid,
    output mul_pkg::mul_result_t result
);

    logic [rs_pkg::rs_size-1:0] alloc;       // one-hot write enable
    logic [rs_pkg::rs_size-1:0] busy;
    logic [rs_pkg::rs_size-1:0] request;     // both operands ready
    logic [rs_pkg::rs_size-1:0] grant;       // one-hot or zero
    logic                       issue_grant_any;
    logic                       issue_valid;
    mul_pkg::mul_issue_t        issue;
    mul_pkg::mul_issue_t        entry_issue [rs_pkg::rs_size];

    ////////////////////////////////////////////////////////////
    // station
    ////////////////////////////////////////////////////////////

    rs_dispatch u_rs_dispatch (
        .clock           (clock),
        .reset           (reset),
        .flush           (flush),
        .dispatch_valid  (dispatch_valid),
        .busy            (busy),
        .issue_grant_any (issue_grant_any),
        .alloc           (alloc),
        .full            (full)
    );

    for (genvar i = 0; i < rs_pkg::rs_size; i++) begin : g_entry
        rs_entry u_rs_entry (
            .clock       (clock),
            .reset       (reset),
            .flush       (flush),
            .alloc       (alloc[i]),
            .dispatch    (dispatch),     // same packet to all, alloc picks
            .cdb         (cdb),
            .grant       (grant[i]),
            .busy        (busy[i]),
            .request     (request[i]),
            .entry_issue (entry_issue[i])
        );
    end

    rs_issue_select u_rs_issue_select (
        .clock           (clock),
        .reset           (reset),
        .flush           (flush),
        .request         (request),
        .entry_issue     (entry_issue),
        .grant           (grant),
        .issue_grant_any (issue_grant_any),
        .issue_valid     (issue_valid),
        .issue           (issue)
    );

    ////////////////////////////////////////////////////////////
    // execution
    ////////////////////////////////////////////////////////////

    mul_pipe u_mul_pipe (
        .clock        (clock),
        .reset        (reset),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// ==== verification/rs_mul_sva.sv ====
////////////////////////////////////////////////////////////
// timing and protocol properties of the station top level
// bound into rs_mul_top, watches internal issue wires
// every property is idle while reset is high
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_mul_sva (
    input logic                       clock,
    input logic                       reset,
    input logic                       flush,
    input logic                       dispatch_valid,
    input logic                       full,
    input logic [rs_pkg::rs_size-1:0] grant,
    input logic                       issue_valid,
    input logic                       result_valid
);

    // no back-pressure, the core must hold off
    no_dispatch_when_full: assert property (
        @(posedge clock) disable iff (reset)
        full |-> !dispatch_valid
    ) else $error("dispatch_valid raised while the station is full");

    // three flush free cycles from issue to result
    issue_to_result: assert property (
        @(posedge clock) disable iff (reset)
        issue_valid && !flush ##1 !flush ##1 !flush |=> result_valid
    ) else $error("issue_valid not followed by result_valid three cycles later");

    grant_onehot0: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(grant)
    ) else $error("more than one entry granted in one cycle");

    // flush clears every stage valid on its edge
    flush_kills_results: assert property (
        @(posedge clock) disable iff (reset)
        flush |=> !result_valid
    ) else $error("result_valid seen in the cycle after a flush");

endmodule

bind rs_mul_top rs_mul_sva u_rs_mul_sva (.*);

// ==== verification/rs_mul_tb.sv ====
////////////////////////////////////////////////////////////
// testbench for the multiply reservation station
// results are checked in arrival order against a fifo model
// the tb plays the core, it never dispatches while full
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_mul_tb;

    logic                 clock;
    logic                 reset;
    logic                 dispatch_valid;
    rs_pkg::rs_dispatch_t dispatch;
    rs_pkg::cdb_t         cdb;
    logic                 flush;
    logic                 full;
    logic                 result_valid;
    mul_pkg::mul_result_t result;

    mul_pkg::mul_result_t expect_q [$];   // oldest first
    logic [31:0]          lfsr;           // galois state
    logic [4:0]           rob_next;
    int                   errors;
    int                   checks;
    int                   test_base;      // error count at test start

    rs_mul_top u_rs_mul_top (.*);

    always #10 clock = ~clock;   // 20 ns period

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // one output bit per step, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w    = {w[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return w;
    endfunction

    // rv32m rule, both operands widened to 64 bits, product mod 2^64
    function automatic logic [31:0] expected_product(input mul_pkg::mul_func_e f,
                                                     input logic [31:0] a,
                                                     input logic [31:0] b);
        logic [63:0] sa;
        logic [63:0] ua;
        logic [63:0] sb;
        logic [63:0] ub;
        logic [63:0] p;
        sa = {{32{a[31]}}, a};
        ua = {32'b0, a};
        sb = {{32{b[31]}}, b};
        ub = {32'b0, b};
        case (f)
            mul_pkg::mulh:   p = sa * sb;
            mul_pkg::mulhsu: p = sa * ub;
            default:         p = ua * ub;   // mul low word is sign blind
        endcase
        return (f == mul_pkg::mul) ? p[31:0] : p[63:32];
    endfunction

    function automatic rs_pkg::operand_t value_op(input logic [31:0] v);
        return '{ready: 1'b1, value: v, tag: '0};
    endfunction

    function automatic rs_pkg::operand_t tag_op(input logic [5:0] t);
        return '{ready: 1'b0, value: '0, tag: t};
    endfunction

    // fresh rob index, random dest tag
    function automatic rs_pkg::rs_dispatch_t make_op(input mul_pkg::mul_func_e f,
                                                     input rs_pkg::operand_t a,
                                                     input rs_pkg::operand_t b);
        logic [31:0] r;
        r        = rand_bits(6);
        rob_next = rob_next + 5'd1;
        return '{opa: a, opb: b, func: f, dest: r[5:0], rob: rob_next};
    endfunction

    task automatic predict(input rs_pkg::rs_dispatch_t d, input logic [31:0] a,
                           input logic [31:0] b);
        mul_pkg::mul_result_t r;
        r = '{value: expected_product(d.func, a, b), dest: d.dest, rob: d.rob};
        expect_q.push_back(r);
    endtask

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] want);
        checks++;
        assert (got == want) else begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;   // inputs move just after the edge
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic send(input rs_pkg::rs_dispatch_t d);
        dispatch       = d;
        dispatch_valid = 1'b1;
        next_cycle();
        dispatch_valid = 1'b0;
    endtask

    task automatic broadcast(input logic [5:0] t, input logic [31:0] v);
        cdb = '{valid: 1'b1, tag: t, value: v};
        next_cycle();
        cdb.valid = 1'b0;
    endtask

    // wait until the model is empty
    task automatic drain(input int limit);
        int n;
        n = 0;
        while (expect_q.size() != 0 && n < limit) begin
            next_cycle();
            n++;
        end
        if (expect_q.size() != 0) begin
            $display("timeout at %0t ns, %0d results never arrived", $time, expect_q.size());
            errors++;
            expect_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    // registered outputs, sampled at the edge
    always @(posedge clock) begin : check_results
        mul_pkg::mul_result_t want;
        if (!reset && result_valid) begin
            if (expect_q.size() == 0) begin
                $display("unexpected result at %0t ns, rob %0d, nothing outstanding",
                         $time, result.rob);
                errors++;
            end else begin
                want = expect_q.pop_front();
                compare("result.rob", 32'(result.rob), 32'(want.rob));
                compare("result.dest", 32'(result.dest), 32'(want.dest));
                compare("result.value", result.value, want.value);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    initial begin
        rs_pkg::rs_dispatch_t d;
        logic [31:0]          a;
        logic [31:0]          b;
        clock          = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        cdb            = '0;
        flush          = 1'b0;
        lfsr           = 32'd92;
        rob_next       = '0;
        errors         = 0;
        checks         = 0;
        test_base      = 0;
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;

        // every func, sign corners first then random
        for (int i = 0; i < 16; i++) begin
            a = (i < 4) ? 32'hffff_fff3 : rand_bits(32);
            b = (i < 4) ? 32'h8000_0007 : rand_bits(32);
            d = make_op(mul_pkg::mul_func_e'(i[1:0]), value_op(a), value_op(b));
            predict(d, a, b);
            send(d);
        end
        drain(20);
        end_test("ready_operands");

        a = rand_bits(32);
        b = rand_bits(32);
        d = make_op(mul_pkg::mulh, tag_op(6'd10), tag_op(6'd11));
        send(d);
        idle(4);                              // model empty, any result is an error
        broadcast(6'd10, a);
        broadcast(6'd12, 32'hdead_beef);      // no slot waits on 12
        idle(6);
        predict(d, a, b);
        broadcast(6'd11, b);
        drain(20);
        end_test("cdb_wakeup");

        a = rand_bits(32);
        b = rand_bits(32);
        d = make_op(mul_pkg::mulhsu, tag_op(6'd20), value_op(b));
        predict(d, a, b);
        cdb = '{valid: 1'b1, tag: 6'd20, value: a};   // same cycle as dispatch
        send(d);
        d = make_op(mul_pkg::mulhu, tag_op(6'd21), tag_op(6'd21));
        predict(d, b, b);
        cdb = '{valid: 1'b1, tag: 6'd21, value: b};   // both operands at once
        send(d);
        cdb.valid = 1'b0;
        drain(20);
        end_test("same_cycle_capture");

        a = rand_bits(32);
        for (int i = 0; i < 4; i++) begin
            compare("full", 32'(full), 32'(0));
            b = rand_bits(32);
            d = make_op(mul_pkg::mul_func_e'(i[1:0]), tag_op(6'd30), value_op(b));
            predict(d, a, b);                 // slot i, so issue order is dispatch order
            send(d);
        end
        compare("full", 32'(full), 32'(1));
        broadcast(6'd30, a);                  // wakes all four together
        compare("full", 32'(full), 32'(1));   // first issue is only requested
        next_cycle();
        compare("full", 32'(full), 32'(0));
        drain(20);
        end_test("full_and_order");

        for (int i = 0; i < 3; i++)
            send(make_op(mul_pkg::mul, tag_op(6'(40 + i)), value_op(32'd3)));
        a = rand_bits(32);
        b = rand_bits(32);
        d = make_op(mul_pkg::mulhu, value_op(a), value_op(b));
        predict(d, a, b);
        send(d);                              // fills slot 3, then issues
        idle(1);
        send(make_op(mul_pkg::mul, tag_op(6'd43), value_op(32'd5)));
        compare("full", 32'(full), 32'(1));
        idle(1);                              // op above reaches stage 2
        flush = 1'b1;                         // op above is mid pipe now
        expect_q.delete();
        next_cycle();
        flush = 1'b0;
        compare("full", 32'(full), 32'(0));
        for (int i = 0; i < 4; i++)
            broadcast(6'(40 + i), 32'd7);     // dead slots must not wake
        idle(6);
        a = rand_bits(32);
        b = rand_bits(32);
        d = make_op(mul_pkg::mulh, value_op(a), value_op(b));
        predict(d, a, b);
        send(d);
        drain(20);
        end_test("flush");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/mul_pkg.sv
logic/rs_pkg.sv
logic/rs_dispatch.sv
logic/rs_entry.sv
logic/rs_issue_select.sv
logic/mul_pipe.sv
logic/rs_mul_top.sv
verification/rs_mul_sva.sv
verification/rs_mul_tb.sv

// ==== Makefile ====
SIM   = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = rs_mul_tb
FLIST = flist.f
OBJ   = obj_dir
BIN   = $(OBJ)/V$(TOP)
SRCS  = $(shell grep -v '^+' $(FLIST))
PASS  = ALL CHECKS PASSED

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ)
